// File: vipt_icache.f
hw/icache_pkg.sv
hw/icache_sram.sv
hw/icache_tag_lookup.sv
hw/icache_tag_verify.sv
hw/icache_plru.sv
hw/icache_miss_ctrl.sv
hw/icache_top.sv
tests/icache_tb.sv

// File: Makefile
# Verilator build and run of the VIPT instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= vipt_icache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/icache_stimulus.txt
# test vaddr ptag drop hit way instr (vaddr, ptag, instr in hex; drop 1 poison, 2 no ptag)
# hit 0 on an undropped line is a miss into way, instr is what the refetch returns
1 00401040 12345 0 0 0 50401234
2 00401080 12345 0 0 0 50801234
2 00401044 12345 0 1 0 50441234
2 00401088 12345 0 1 0 50881234
2 004010bc 12345 0 1 0 50bc1234
2 00401040 12345 0 1 0 50401234
2 00401084 12345 0 1 0 50841234
3 00401040 12345 1 0 0 00000000
3 00401100 55555 2 0 0 00000000
3 00401140 55555 1 0 0 00000000
3 00401044 12345 0 1 0 50441234
4 00000140 0a000 0 0 0 01400a00
4 00000144 0b000 0 0 1 01440b00
4 00000148 0c000 0 0 2 01480c00
4 0000014c 0d000 0 0 3 014c0d00
4 00000150 0a000 0 1 0 01500a00
4 00000154 0e000 0 0 2 01540e00
4 00000158 0f000 0 0 1 01580f00
4 0000015c 0c000 0 0 3 015c0c00
4 00000140 0a000 0 1 0 01400a00
5 00802040 54321 0 0 1 10405432
5 00401040 12345 0 1 0 50401234
5 00802044 54321 0 1 0 10445432
6 7f000ffc fffff 0 0 0 fffcffff
6 7f000fc0 fffff 0 1 0 ffc0ffff

// File: tests/icache_tb.sv
/* testbench for the VIPT instruction cache: clock, reset, memory engine
   model, stimulus file reader, checks and report */

`timescale 1ns/1ps

module icache_tb;

  localparam int max_lines_c = 64;
  localparam int reset_cycles_c = 10;
  localparam int block_words_c = 16;

  logic          clk_i;
  logic          reset_i;
  logic          v_i;
  logic [31:0]   vaddr_i;
  logic          ready_o;
  logic [19:0]   ptag_i;
  logic          ptag_v_i;
  logic          poison_i;
  logic [31:0]   data_o;
  logic          data_v_o;
  logic          cache_req_v_o;
  logic [31:0]   cache_req_addr_o;
  logic          cache_req_ready_i;
  logic          fill_v_i;
  logic [511:0]  fill_data_i;
  logic          fill_yumi_o;

  // one entry per stimulus line
  int            line_test [max_lines_c];
  logic [31:0]   line_vaddr [max_lines_c];
  logic [19:0]   line_ptag [max_lines_c];
  int            line_drop [max_lines_c];
  int            line_hit [max_lines_c];
  int            line_way [max_lines_c];
  logic [31:0]   line_instr [max_lines_c];
  int            num_lines;
  int            test_errs [8];
  int            test_last [8];
  int            errors = 0;
  int            tests_passed = 0;
  int            tests_failed = 0;
  int            cycles = 0;
  int            cycle_limit = 100000;
  logic [31:0]   lfsr = 32'h435;

  always begin
    clk_i = 1'b0;
    #10;
    clk_i = 1'b1;
    #10;
  end

  icache_top dut0 (
    .clk_i(clk_i), .reset_i(reset_i), .v_i(v_i), .vaddr_i(vaddr_i), .ready_o(ready_o),
    .ptag_i(ptag_i), .ptag_v_i(ptag_v_i), .poison_i(poison_i), .data_o(data_o),
    .data_v_o(data_v_o), .cache_req_v_o(cache_req_v_o), .cache_req_addr_o(cache_req_addr_o),
    .cache_req_ready_i(cache_req_ready_i), .fill_v_i(fill_v_i), .fill_data_i(fill_data_i),
    .fill_yumi_o(fill_yumi_o)
  );

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the cache stopped making progress", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // engine data: the word at address a is a with its halves swapped
  function automatic logic [31:0] swap_halves(logic [31:0] a);
    return {a[15:0], a[31:16]};
  endfunction

  function automatic logic [511:0] make_block(logic [31:0] base);
    logic [511:0] blk;
    for (int w = 0; w < block_words_c; w++) begin
      blk[32*w +: 32] = swap_halves(base + 32'(4 * w));
    end
    return blk;
  endfunction

  function automatic string test_name(int t);
    case (t)
      1: return "cold miss";
      2: return "back to back";
      3: return "dropped fetch";
      4: return "replacement";
      5: return "physical tag";
      default: return "miss stall";
    endcase
  endfunction

  task automatic report_value(input int t, input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("** Error %s: %s expected %h, actual %h", test_name(t), what, exp, act);
    test_errs[t]++;
    errors++;
  endtask

  task automatic report_event(input int t, input string msg);
    $display("%s: %s", test_name(t), msg);
    test_errs[t]++;
    errors++;
  endtask

  task automatic finish_test(input int t);
    if (test_errs[t] == 0) begin
      $display("test %0d %s passed", t, test_name(t));
      tests_passed++;
    end else begin
      $display("test %0d %s failed with %0d errors", t, test_name(t), test_errs[t]);
      tests_failed++;
    end
  endtask

  // memory engine side of one miss, entered in the TV miss cycle
  task automatic serve_miss(input int i);
    int t;
    int delay;
    logic [31:0] req_addr;
    t = line_test[i];
    req_addr = {line_ptag[i], line_vaddr[i][11:6], 6'b0};
    random_bits(2, delay);
    for (int c = 0; c <= delay; c++) begin
      @(posedge clk_i);
      cache_req_ready_i <= (c == delay);
      @(negedge clk_i);
      if (cache_req_v_o !== 1'b1) report_value(t, "cache_req_v_o", 1, 32'(cache_req_v_o));
      if (cache_req_addr_o !== req_addr) report_value(t, "cache_req_addr_o", req_addr,
                                                      cache_req_addr_o);
      if (ready_o !== 1'b0) report_value(t, "ready_o during request", 0, 32'(ready_o));
    end
    random_bits(2, delay);
    for (int c = 0; c <= delay; c++) begin
      @(posedge clk_i);
      cache_req_ready_i <= 1'b0;
      fill_data_i <= make_block(req_addr);
      fill_v_i <= (c == delay);
      @(negedge clk_i);
      if (cache_req_v_o !== 1'b0) report_value(t, "cache_req_v_o after accept", 0,
                                               32'(cache_req_v_o));
      if (ready_o !== 1'b0) report_value(t, "ready_o during fill wait", 0, 32'(ready_o));
      if (fill_yumi_o !== (c == delay)) report_value(t, "fill_yumi_o", 32'(c == delay),
                                                     32'(fill_yumi_o));
    end
    if (dut0.fill_way !== 2'(line_way[i])) report_value(t, "replacement way",
                                                        32'(line_way[i]), 32'(dut0.fill_way));
    @(posedge clk_i);
    fill_v_i <= 1'b0;
    @(negedge clk_i);
    if (ready_o !== 1'b1) report_event(t, "ready_o did not rise the cycle after the fill");
  endtask

  // consumer refetch after a miss, fully serial
  task automatic refetch(input int i);
    int t;
    t = line_test[i];
    @(posedge clk_i);
    v_i <= 1'b1;
    vaddr_i <= line_vaddr[i];
    @(posedge clk_i);
    v_i <= 1'b0;
    ptag_i <= line_ptag[i];
    ptag_v_i <= 1'b1;
    poison_i <= 1'b0;
    @(posedge clk_i);
    ptag_v_i <= 1'b0;
    @(negedge clk_i);
    if (data_v_o !== 1'b1) report_value(t, "data_v_o on refetch", 1, 32'(data_v_o));
    if (data_o !== line_instr[i]) report_value(t, "data_o on refetch", line_instr[i], data_o);
  endtask

  // runs in cycle N+2 of the fetch from line i
  task automatic check_line(input int i);
    int t;
    t = line_test[i];
    if (line_drop[i] != 0) begin
      if (data_v_o !== 1'b0) report_value(t, "data_v_o on dropped fetch", 0, 32'(data_v_o));
      if (ready_o !== 1'b1) report_event(t, "a dropped fetch raised a miss");
    end else if (line_hit[i] != 0) begin
      if (data_v_o !== 1'b1) report_value(t, "data_v_o", 1, 32'(data_v_o));
      if (data_o !== line_instr[i]) report_value(t, "data_o", line_instr[i], data_o);
    end else begin
      if (data_v_o !== 1'b0) report_value(t, "data_v_o on miss", 0, 32'(data_v_o));
      if (ready_o !== 1'b0) report_value(t, "ready_o in miss cycle", 0, 32'(ready_o));
      serve_miss(i);
      refetch(i);
    end
    if (i == test_last[t]) finish_test(t);
  endtask

  initial begin
    int fd;
    int q1;
    int q2;
    int cur;
    int next;
    bit stall;
    string text;
    reset_i = 1'b1;
    v_i = 1'b0;
    vaddr_i = '0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    cache_req_ready_i = 1'b0;
    fill_v_i = 1'b0;
    fill_data_i = '0;

    num_lines = 0;
    fd = $fopen("tests/icache_stimulus.txt", "r");
    if (fd == 0) begin
      report_event(1, "could not open tests/icache_stimulus.txt");
    end else begin
      while (!$feof(fd) && num_lines < max_lines_c) begin
        if ($fgets(text, fd) == 0) break;
        if (text.len() < 2 || text[0] == "#") continue;
        if ($sscanf(text, "%d %h %h %d %d %d %h", line_test[num_lines],
                    line_vaddr[num_lines], line_ptag[num_lines], line_drop[num_lines],
                    line_hit[num_lines], line_way[num_lines],
                    line_instr[num_lines]) == 7) begin
          test_last[line_test[num_lines]] = num_lines;
          num_lines++;
        end
      end
      $fclose(fd);
    end
    cycle_limit = num_lines * 80 + reset_cycles_c;

    repeat (reset_cycles_c) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (ready_o !== 1'b1) report_event(6, "ready_o low after reset");
    if (cache_req_v_o !== 1'b0) report_event(6, "miss request raised after reset");
    if (num_lines == 0) report_event(1, "no fetches found in the stimulus file");

    // fetches issue back to back until a miss is expected
    q1 = -1;
    q2 = -1;
    next = 0;
    stall = 1'b0;
    while (next < num_lines || q1 >= 0 || q2 >= 0) begin
      @(posedge clk_i);
      if (q1 >= 0) begin
        ptag_i <= line_ptag[q1];
        ptag_v_i <= (line_drop[q1] != 2);
        poison_i <= (line_drop[q1] == 1);
      end else begin
        ptag_v_i <= 1'b0;
        poison_i <= 1'b0;
      end
      cur = -1;
      if (!stall && next < num_lines) begin
        cur = next;
        next++;
        stall = (line_drop[cur] == 0) && (line_hit[cur] == 0);
      end
      v_i <= (cur >= 0);
      if (cur >= 0) vaddr_i <= line_vaddr[cur];
      @(negedge clk_i);
      if (q2 >= 0) begin
        check_line(q2);
        if (line_drop[q2] == 0 && line_hit[q2] == 0) stall = 1'b0;
      end
      q2 = q1;
      q1 = cur;
    end

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hw/icache_top.sv
/* VIPT instruction cache top: TL and TV stages,
   pseudo-LRU and miss controller */

`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
#(
  parameter int sets_p = default_sets_c,
  parameter int assoc_p = default_assoc_c,
  parameter int block_width_p = default_block_width_c,
  parameter int ptag_width_p = default_ptag_width_c
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         v_i,
  input  logic [vaddr_width_c-1:0]                     vaddr_i,
  output logic                                         ready_o,
  input  logic [ptag_width_p-1:0]                      ptag_i,
  input  logic                                         ptag_v_i,
  input  logic                                         poison_i,
  output instr_t                                       data_o,
  output logic                                         data_v_o,
  output logic                                         cache_req_v_o,
  output logic [ptag_width_p+page_offset_width_c-1:0]  cache_req_addr_o,
  input  logic                                         cache_req_ready_i,
  input  logic                                         fill_v_i,
  input  logic [block_width_p-1:0]                     fill_data_i,
  output logic                                         fill_yumi_o
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int way_width_lp = $clog2(assoc_p);
  localparam int block_offset_width_lp = $clog2(block_width_p / 8);
  localparam int paddr_width_lp = ptag_width_p + page_offset_width_c;

  // index must come from untranslated bits
  if (index_width_lp + block_offset_width_lp > page_offset_width_c) begin : g_geom_chk
    $error("index and block offset exceed the page offset");
  end

  logic                                   fetch_acc;
  logic                                   tl_v;
  logic [vaddr_width_c-1:0]               tl_vaddr;
  logic [assoc_p-1:0][ptag_width_p-1:0]   tl_tags;
  logic [assoc_p-1:0][block_width_p-1:0]  tl_lines;
  logic [assoc_p-1:0]                     tl_valid;
  logic                                   tv_miss;
  logic [paddr_width_lp-1:0]              tv_paddr;
  logic [assoc_p-1:0]                     tv_valid;
  logic                                   hit_v;
  logic [way_width_lp-1:0]                hit_way;
  logic [way_width_lp-1:0]                victim;
  logic                                   busy;
  logic                                   fill_we;
  logic [index_width_lp-1:0]              fill_index;
  logic [way_width_lp-1:0]                fill_way;
  logic [ptag_width_p-1:0]                fill_tag;
  logic [block_width_p-1:0]               fill_data;

  // stall from the miss cycle in TV until the fill is taken
  assign ready_o = ~busy & ~tv_miss;
  assign fetch_acc = v_i & ready_o;

  icache_tag_lookup #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p),
                      .ptag_width_p(ptag_width_p)) tl (
    .clk_i(clk_i), .reset_i(reset_i), .fetch_acc_i(fetch_acc), .vaddr_i(vaddr_i),
    .poison_i(poison_i), .ptag_v_i(ptag_v_i), .squash_i(tv_miss),
    .fill_we_i(fill_we), .fill_index_i(fill_index), .fill_way_i(fill_way),
    .fill_tag_i(fill_tag), .fill_data_i(fill_data), .tl_v_o(tl_v), .tl_vaddr_o(tl_vaddr),
    .tags_o(tl_tags), .lines_o(tl_lines), .valid_o(tl_valid)
  );

  icache_tag_verify #(.assoc_p(assoc_p), .block_width_p(block_width_p),
                      .ptag_width_p(ptag_width_p)) tv (
    .clk_i(clk_i), .reset_i(reset_i), .tl_v_i(tl_v), .tl_vaddr_i(tl_vaddr),
    .ptag_i(ptag_i), .tags_i(tl_tags), .lines_i(tl_lines), .valid_i(tl_valid),
    .data_o(data_o), .data_v_o(data_v_o), .tv_miss_o(tv_miss), .tv_paddr_o(tv_paddr),
    .tv_valid_o(tv_valid), .hit_v_o(hit_v), .hit_way_o(hit_way)
  );

  icache_plru #(.sets_p(sets_p), .assoc_p(assoc_p)) plru (
    .clk_i(clk_i), .reset_i(reset_i), .hit_v_i(hit_v), .hit_way_i(hit_way),
    .index_i(tv_paddr[block_offset_width_lp +: index_width_lp]),
    .fill_we_i(fill_we), .fill_index_i(fill_index), .fill_way_i(fill_way),
    .victim_o(victim)
  );

  icache_miss_ctrl #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p),
                     .ptag_width_p(ptag_width_p)) miss (
    .clk_i(clk_i), .reset_i(reset_i), .tv_miss_i(tv_miss), .tv_paddr_i(tv_paddr),
    .tv_valid_i(tv_valid), .victim_i(victim), .cache_req_ready_i(cache_req_ready_i),
    .fill_v_i(fill_v_i), .fill_data_i(fill_data_i), .cache_req_v_o(cache_req_v_o),
    .cache_req_addr_o(cache_req_addr_o), .fill_yumi_o(fill_yumi_o), .busy_o(busy),
    .fill_we_o(fill_we), .fill_index_o(fill_index), .fill_way_o(fill_way),
    .fill_tag_o(fill_tag), .fill_data_o(fill_data)
  );

endmodule

// File: hw/icache_miss_ctrl.sv
/* miss FSM: holds the block request and replacement way,
   accepts the fill block and issues the array write */

`timescale 1ns/1ps

module icache_miss_ctrl
  import icache_pkg::*;
#(
  parameter int sets_p = default_sets_c,
  parameter int assoc_p = default_assoc_c,
  parameter int block_width_p = default_block_width_c,
  parameter int ptag_width_p = default_ptag_width_c
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         tv_miss_i,
  input  logic [ptag_width_p+page_offset_width_c-1:0]  tv_paddr_i,
  input  logic [assoc_p-1:0]                           tv_valid_i,
  input  logic [$clog2(assoc_p)-1:0]                   victim_i,
  input  logic                                         cache_req_ready_i,
  input  logic                                         fill_v_i,
  input  logic [block_width_p-1:0]                     fill_data_i,
  output logic                                         cache_req_v_o,
  output logic [ptag_width_p+page_offset_width_c-1:0]  cache_req_addr_o,
  output logic                                         fill_yumi_o,
  output logic                                         busy_o,
  output logic                                         fill_we_o,
  output logic [$clog2(sets_p)-1:0]                    fill_index_o,
  output logic [$clog2(assoc_p)-1:0]                   fill_way_o,
  output logic [ptag_width_p-1:0]                      fill_tag_o,
  output logic [block_width_p-1:0]                     fill_data_o
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int way_width_lp = $clog2(assoc_p);
  localparam int block_offset_width_lp = $clog2(block_width_p / 8);
  localparam int paddr_width_lp = ptag_width_p + page_offset_width_c;

  typedef enum logic [1:0] {idle_s, req_s, wait_fill_s} state_e;

  state_e                     state_r;
  logic [paddr_width_lp-1:0]  addr_r;
  logic [way_width_lp-1:0]    way_r;
  logic [way_width_lp-1:0]    repl_way;

  // lowest invalid way wins, else the LRU pick
  always_comb begin
    repl_way = victim_i;
    for (int w = assoc_p - 1; w >= 0; w--) begin
      if (!tv_valid_i[w]) begin
        repl_way = way_width_lp'(w);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle_s;
    end else begin
      case (state_r)
        idle_s:      state_r <= tv_miss_i ? req_s : idle_s;
        req_s:       state_r <= cache_req_ready_i ? wait_fill_s : req_s;
        wait_fill_s: state_r <= fill_v_i ? idle_s : wait_fill_s;
        default:     state_r <= idle_s;
      endcase
    end
  end

  // block-aligned miss address and chosen way
  always_ff @(posedge clk_i) begin
    if ((state_r == idle_s) && tv_miss_i) begin
      addr_r <= {tv_paddr_i[paddr_width_lp-1:block_offset_width_lp],
                 {block_offset_width_lp{1'b0}}};
      way_r  <= repl_way;
    end
  end

  assign cache_req_v_o = (state_r == req_s);
  assign cache_req_addr_o = addr_r;
  assign fill_yumi_o = (state_r == wait_fill_s) & fill_v_i;
  assign busy_o = (state_r != idle_s);

  // whole block lands in the array in the accept cycle
  assign fill_we_o = fill_yumi_o;
  assign fill_index_o = addr_r[block_offset_width_lp +: index_width_lp];
  assign fill_way_o = way_r;
  assign fill_tag_o = addr_r[paddr_width_lp-1 -: ptag_width_p];
  assign fill_data_o = fill_data_i;

  // the stall upstream must keep a second miss away while one is open
  a_miss_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    tv_miss_i |-> (state_r == idle_s))
    else $error("miss from TV while a miss is outstanding");

endmodule

// File: hw/icache_plru.sv
/* per-set pseudo-LRU tree with hit and fill update
   and victim decode for the TV set */

`timescale 1ns/1ps

module icache_plru #(
  parameter int sets_p = 64,
  parameter int assoc_p = 4
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        hit_v_i,
  input  logic [$clog2(assoc_p)-1:0]  hit_way_i,
  input  logic [$clog2(sets_p)-1:0]   index_i,
  input  logic                        fill_we_i,
  input  logic [$clog2(sets_p)-1:0]   fill_index_i,
  input  logic [$clog2(assoc_p)-1:0]  fill_way_i,
  output logic [$clog2(assoc_p)-1:0]  victim_o
);

  localparam int way_width_lp = $clog2(assoc_p);

  // node n has children 2n+1 and 2n+2; a bit of 1 sends the victim right
  logic [sets_p-1:0][assoc_p-2:0] tree_r;

  // point every node on the way's path to the other side
  function automatic logic [assoc_p-2:0] touch(logic [assoc_p-2:0] tree,
                                               logic [way_width_lp-1:0] way);
    int node;
    logic dir;
    node = 0;
    for (int l = way_width_lp - 1; l >= 0; l--) begin
      dir = way[l];
      tree[node] = ~dir;
      node = 2 * node + 1 + int'(dir);
    end
    return tree;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tree_r <= '0;
    end else if (fill_we_i) begin
      tree_r[fill_index_i] <= touch(tree_r[fill_index_i], fill_way_i);
    end else if (hit_v_i) begin
      tree_r[index_i] <= touch(tree_r[index_i], hit_way_i);
    end
  end

  // walk down from the root
  always_comb begin
    int node;
    logic dir;
    node = 0;
    victim_o = '0;
    for (int l = way_width_lp - 1; l >= 0; l--) begin
      dir = tree_r[index_i][node];
      victim_o[l] = dir;
      node = 2 * node + 1 + int'(dir);
    end
  end

endmodule

// File: hw/icache_tag_verify.sv
/* TV stage: registered lookup results, tag hit detection,
   instruction select and miss flag */

`timescale 1ns/1ps

module icache_tag_verify
  import icache_pkg::*;
#(
  parameter int assoc_p = default_assoc_c,
  parameter int block_width_p = default_block_width_c,
  parameter int ptag_width_p = default_ptag_width_c
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         tl_v_i,
  input  logic [vaddr_width_c-1:0]                     tl_vaddr_i,
  input  logic [ptag_width_p-1:0]                      ptag_i,
  input  logic [assoc_p-1:0][ptag_width_p-1:0]         tags_i,
  input  logic [assoc_p-1:0][block_width_p-1:0]        lines_i,
  input  logic [assoc_p-1:0]                           valid_i,
  output instr_t                                       data_o,
  output logic                                         data_v_o,
  output logic                                         tv_miss_o,
  output logic [ptag_width_p+page_offset_width_c-1:0]  tv_paddr_o,
  output logic [assoc_p-1:0]                           tv_valid_o,
  output logic                                         hit_v_o,
  output logic [$clog2(assoc_p)-1:0]                   hit_way_o
);

  localparam int way_width_lp = $clog2(assoc_p);
  localparam int paddr_width_lp = ptag_width_p + page_offset_width_c;
  localparam int words_lp = block_width_p / instr_width_c;
  localparam int word_sel_width_lp = $clog2(words_lp);

  logic [assoc_p-1:0]                     hit_tl;
  logic                                   tv_v_r;
  logic [assoc_p-1:0]                     tv_hit_r;
  logic [assoc_p-1:0]                     tv_valid_r;
  logic [paddr_width_lp-1:0]              tv_paddr_r;
  logic [assoc_p-1:0][block_width_p-1:0]  tv_lines_r;
  logic [block_width_p-1:0]               hit_line;
  logic [way_width_lp-1:0]                hit_way;
  instr_t [words_lp-1:0]                  hit_words;
  logic                                   tv_hit;

  // tag compare while the physical tag arrives
  always_comb begin
    for (int w = 0; w < assoc_p; w++) begin
      hit_tl[w] = valid_i[w] && (tags_i[w] == ptag_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end else begin
      tv_v_r <= tl_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_v_i) begin
      tv_hit_r   <= hit_tl;
      tv_valid_r <= valid_i;
      tv_paddr_r <= {ptag_i, tl_vaddr_i[page_offset_width_c-1:0]};
      tv_lines_r <= lines_i;
    end
  end

  // hit way mux, one-hot by construction
  always_comb begin
    hit_line = '0;
    hit_way = '0;
    for (int w = 0; w < assoc_p; w++) begin
      if (tv_hit_r[w]) begin
        hit_line = tv_lines_r[w];
        hit_way = way_width_lp'(w);
      end
    end
  end

  assign hit_words = hit_line;
  assign tv_hit = |tv_hit_r;

  // word offset picks the instruction
  assign data_o = hit_words[tv_paddr_r[2 +: word_sel_width_lp]];
  assign data_v_o = tv_v_r & tv_hit;
  assign tv_miss_o = tv_v_r & ~tv_hit;
  assign tv_paddr_o = tv_paddr_r;
  assign tv_valid_o = tv_valid_r;
  assign hit_v_o = tv_v_r & tv_hit;
  assign hit_way_o = hit_way;

  // a block must never sit in two ways of one set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    tv_v_r |-> $onehot0(tv_hit_r))
    else $error("tag hit in more than one way");

endmodule

// File: hw/icache_tag_lookup.sv
/* TL stage: fetch register, tag and data array addressing,
   per-line valid bits and fill writes */

`timescale 1ns/1ps

module icache_tag_lookup
  import icache_pkg::*;
#(
  parameter int sets_p = default_sets_c,
  parameter int assoc_p = default_assoc_c,
  parameter int block_width_p = default_block_width_c,
  parameter int ptag_width_p = default_ptag_width_c
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   fetch_acc_i,
  input  logic [vaddr_width_c-1:0]               vaddr_i,
  input  logic                                   poison_i,
  input  logic                                   ptag_v_i,
  input  logic                                   squash_i,
  input  logic                                   fill_we_i,
  input  logic [$clog2(sets_p)-1:0]              fill_index_i,
  input  logic [$clog2(assoc_p)-1:0]             fill_way_i,
  input  logic [ptag_width_p-1:0]                fill_tag_i,
  input  logic [block_width_p-1:0]               fill_data_i,
  output logic                                   tl_v_o,
  output logic [vaddr_width_c-1:0]               tl_vaddr_o,
  output logic [assoc_p-1:0][ptag_width_p-1:0]   tags_o,
  output logic [assoc_p-1:0][block_width_p-1:0]  lines_o,
  output logic [assoc_p-1:0]                     valid_o
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int block_offset_width_lp = $clog2(block_width_p / 8);

  typedef logic [ptag_width_p-1:0] tag_t;
  typedef logic [block_width_p-1:0] line_t;

  logic [index_width_lp-1:0]       fetch_index;
  logic [index_width_lp-1:0]       arr_addr;
  logic [assoc_p-1:0]              fill_way_oh;
  logic [sets_p-1:0][assoc_p-1:0]  valid_r;
  logic                            tl_v_r;
  logic [vaddr_width_c-1:0]        tl_vaddr_r;
  logic [assoc_p-1:0]              tl_valid_r;

  assign fetch_index = vaddr_i[block_offset_width_lp +: index_width_lp];

  // a fill owns the arrays, fetches are held off meanwhile
  assign arr_addr = fill_we_i ? fill_index_i : fetch_index;

  always_comb begin
    fill_way_oh = '0;
    fill_way_oh[fill_way_i] = fill_we_i;
  end

  icache_sram #(.ways_p(assoc_p), .sets_p(sets_p), .entry_t(tag_t)) tag_mem (
    .clk_i(clk_i), .en_i(fetch_acc_i), .we_i(fill_way_oh), .addr_i(arr_addr),
    .wdata_i(fill_tag_i), .rdata_o(tags_o)
  );

  icache_sram #(.ways_p(assoc_p), .sets_p(sets_p), .entry_t(line_t)) data_mem (
    .clk_i(clk_i), .en_i(fetch_acc_i), .we_i(fill_way_oh), .addr_i(arr_addr),
    .wdata_i(fill_data_i), .rdata_o(lines_o)
  );

  // one valid bit per line
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (fill_we_i) begin
      valid_r[fill_index_i][fill_way_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= fetch_acc_i;
    end
  end

  // valid bits sampled alongside the array read
  always_ff @(posedge clk_i) begin
    if (fetch_acc_i) begin
      tl_vaddr_r <= vaddr_i;
      tl_valid_r <= valid_r[fetch_index];
    end
  end

  // drop poisoned, untranslated or squashed fetches here
  assign tl_v_o = tl_v_r & ptag_v_i & ~poison_i & ~squash_i;
  assign tl_vaddr_o = tl_vaddr_r;
  assign valid_o = tl_valid_r;

endmodule

// File: hw/icache_sram.sv
/* synchronous single-port array, one lane per way, with a type
   parameter for the stored entry */

`timescale 1ns/1ps

module icache_sram #(
  parameter int ways_p = 4,
  parameter int sets_p = 64,
  parameter type entry_t = logic [31:0]
) (
  input  logic                        clk_i,
  input  logic                        en_i,
  input  logic [ways_p-1:0]           we_i,
  input  logic [$clog2(sets_p)-1:0]   addr_i,
  input  entry_t                      wdata_i,
  output entry_t [ways_p-1:0]         rdata_o
);

  for (genvar w = 0; w < ways_p; w++) begin : g_lane
    entry_t mem_r [sets_p];
    entry_t rdata_r;

    // write only the lanes picked by we_i
    always_ff @(posedge clk_i) begin
      if (we_i[w]) begin
        mem_r[addr_i] <= wdata_i;
      end
    end

    // read data shows up the cycle after the address
    always_ff @(posedge clk_i) begin
      if (en_i) begin
        rdata_r <= mem_r[addr_i];
      end
    end

    assign rdata_o[w] = rdata_r;
  end

  // fills only happen while the fetch side is stalled
  a_no_rw_collision: assert property (@(posedge clk_i) !(en_i && (|we_i)))
    else $error("array read and written in the same cycle");

endmodule

// File: hw/icache_pkg.sv
/* shared constants, the instruction word type and default cache geometry
   for the VIPT instruction cache */

package icache_pkg;

  // instruction word
  localparam int instr_width_c = 32;
  typedef logic [instr_width_c-1:0] instr_t;

  // untranslated part of the address; index and block offset live here
  localparam int page_offset_width_c = 12;
  localparam int vaddr_width_c = 32;

  // default geometry: 64 sets, 4 ways, 64 byte blocks
  localparam int default_sets_c = 64;
  localparam int default_assoc_c = 4;
  localparam int default_block_width_c = 512;

  // 20 bit physical tag gives a 32 bit physical address
  localparam int default_ptag_width_c = 20;

endpackage
